// ==== mic_audio_pkg.sv ====
package mic_audio_pkg;

  // audio sample width
  localparam int SAMPLE_W = 16;

  // sine amplitude width
  localparam int TONE_W = 8;

  // phase accumulator width
  localparam int PHASE_W = 32;

  localparam int NUM_TAPS = 8;

  // coefficients sum to 256, so the shift gives unity DC gain
  localparam int FIR_SHIFT = 8;
  localparam logic signed [7:0] FIR_COEFFS [NUM_TAPS] = '{
    8'sd4, 8'sd16, 8'sd36, 8'sd72, 8'sd72, 8'sd36, 8'sd16, 8'sd4
  };

  // sample with its one-cycle strobe
  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
  } audio_sample_t;

  // first quadrant, round(127 * sin((i + 0.5) * pi / 32))
  localparam logic signed [TONE_W-1:0] SINE_QUARTER [16] = '{
    8'sd6, 8'sd19, 8'sd31, 8'sd43, 8'sd54, 8'sd65, 8'sd76, 8'sd85,
    8'sd94, 8'sd102, 8'sd109, 8'sd115, 8'sd120, 8'sd123, 8'sd126, 8'sd127
  };

  // 6-bit phase to signed amplitude
  function automatic logic signed [TONE_W-1:0] sine_lookup(input logic [5:0] phase);
    logic [3:0]               idx;
    logic signed [TONE_W-1:0] mag;
    // odd quadrants run the table backwards
    idx = phase[4] ? ~phase[3:0] : phase[3:0];
    mag = SINE_QUARTER[idx];
    // second half of the cycle is negative
    return phase[5] ? -mag : mag;
  endfunction

endpackage

// ==== i2s_receiver.sv ====
`timescale 1ns/100ps

module i2s_receiver import mic_audio_pkg::*; #(
  parameter int unsigned BCLK_HALF = 16
) (
  input  logic          audio_clk,
  input  logic          reset,
  input  logic          mic_data,
  output logic          i2s_clk,
  output logic          lrcl_clk,
  output audio_sample_t mic_sample
);

  localparam int HALF_W = (BCLK_HALF > 1) ? $clog2(BCLK_HALF) : 1;

  logic [HALF_W-1:0]          half_cnt;
  logic [5:0]                 bit_cnt;
  logic                       half_end;
  logic                       bclk_rise;
  logic                       bclk_fall;
  logic                       capture_bit;
  logic [SAMPLE_W-1:0]        shift_reg;
  logic                       sample_valid;

  assign half_end  = (half_cnt == HALF_W'(BCLK_HALF - 1));
  assign bclk_rise = half_end && !i2s_clk;
  assign bclk_fall = half_end && i2s_clk;

  // bit periods 1..16 of the left slot hold the sample, MSB first
  assign capture_bit = bclk_rise && (bit_cnt >= 6'd1) && (bit_cnt <= 6'd16);

  // word select follows the upper half of the frame
  assign lrcl_clk = bit_cnt[5];

  // bit clock and frame position
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      half_cnt <= '0;
      i2s_clk  <= 1'b0;
      bit_cnt  <= '0;
    end else begin
      if (half_end) begin
        half_cnt <= '0;
        i2s_clk  <= ~i2s_clk;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
      // bit period ends on the falling edge
      if (bclk_fall) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // strobe for the sixteenth bit
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= bclk_rise && (bit_cnt == 6'd16);
    end
  end

  // shift register, holds the full word until the next left slot
  always_ff @(posedge audio_clk) begin
    if (capture_bit) begin
      shift_reg <= {shift_reg[SAMPLE_W-2:0], mic_data};
    end
  end

  assign mic_sample = '{valid: sample_valid, data: shift_reg};

  // one strobe per frame, never back to back
  assert property (@(posedge audio_clk) disable iff (reset)
    sample_valid |=> !sample_valid);

  // word select moves only during the low half of the bit clock
  assert property (@(posedge audio_clk) disable iff (reset)
    $changed(lrcl_clk) |-> !i2s_clk);

endmodule

// ==== fir_decimator.sv ====
`timescale 1ns/100ps

module fir_decimator import mic_audio_pkg::*; (
  input  logic          audio_clk,
  input  logic          reset,
  input  audio_sample_t sample_in,
  output audio_sample_t sample_out
);

  localparam int TAP_W = $clog2(NUM_TAPS);
  // product plus growth over the taps, with a spare bit
  localparam int ACC_W = SAMPLE_W + 8 + TAP_W + 1;
  localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(NUM_TAPS - 1);
  localparam logic signed [ACC_W-1:0] SAT_MAX = (ACC_W'(1) <<< (SAMPLE_W - 1)) - 1;
  localparam logic signed [ACC_W-1:0] SAT_MIN = -(ACC_W'(1) <<< (SAMPLE_W - 1));

  logic signed [SAMPLE_W-1:0] delay_line [NUM_TAPS];
  logic [TAP_W-1:0]           tap;
  logic                       mac_active;
  logic                       sat_stage;
  logic signed [ACC_W-1:0]    acc;
  logic signed [ACC_W-1:0]    acc_shifted;
  logic signed [SAMPLE_W-1:0] sat_data;
  logic                       keep;
  logic                       out_valid;
  logic signed [SAMPLE_W-1:0] out_data;

  // newest sample at index 0
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        delay_line[i] <= '0;
      end
    end else if (sample_in.valid) begin
      delay_line[0] <= sample_in.data;
      for (int i = 1; i < NUM_TAPS; i++) begin
        delay_line[i] <= delay_line[i-1];
      end
    end
  end

  // tap sequencing, one MAC per cycle then a saturation cycle
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      mac_active <= 1'b0;
      sat_stage  <= 1'b0;
      tap        <= '0;
      keep       <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      sat_stage <= mac_active && (tap == LAST_TAP);
      out_valid <= sat_stage && keep;
      // every second result goes out
      if (sat_stage) begin
        keep <= ~keep;
      end
      if (sample_in.valid) begin
        mac_active <= 1'b1;
        tap        <= '0;
      end else if (mac_active) begin
        tap <= tap + 1'b1;
        if (tap == LAST_TAP) begin
          mac_active <= 1'b0;
        end
      end
    end
  end

  // accumulator
  always_ff @(posedge audio_clk) begin
    if (sample_in.valid) begin
      acc <= '0;
    end else if (mac_active) begin
      acc <= acc + delay_line[tap] * FIR_COEFFS[tap];
    end
  end

  assign acc_shifted = acc >>> FIR_SHIFT;

  // clamp to the sample range
  always_comb begin
    if (acc_shifted > SAT_MAX) begin
      sat_data = SAT_MAX[SAMPLE_W-1:0];
    end else if (acc_shifted < SAT_MIN) begin
      sat_data = SAT_MIN[SAMPLE_W-1:0];
    end else begin
      sat_data = acc_shifted[SAMPLE_W-1:0];
    end
  end

  always_ff @(posedge audio_clk) begin
    if (sat_stage) begin
      out_data <= sat_data;
    end
  end

  assign sample_out = '{valid: out_valid, data: out_data};

  // the receiver must leave room for a full pass over the taps
  assert property (@(posedge audio_clk) disable iff (reset)
    sample_in.valid |-> !(mac_active || sat_stage));

endmodule

// ==== sine_generator.sv ====
`timescale 1ns/100ps

module sine_generator import mic_audio_pkg::*; #(
  parameter logic [PHASE_W-1:0] PHASE_INCR_A = 32'h0100_0000,
  parameter logic [PHASE_W-1:0] PHASE_INCR_B = 32'h0040_0000
) (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  logic                     step,
  input  logic                     tone_select,
  output logic signed [TONE_W-1:0] amplitude
);

  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] phase_incr;

  // pick the step size
  assign phase_incr = tone_select ? PHASE_INCR_B : PHASE_INCR_A;

  // phase advances once per trigger
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      phase <= '0;
    end else if (step) begin
      phase <= phase + phase_incr;
    end
  end

  // top six phase bits address the table
  always_ff @(posedge audio_clk) begin
    amplitude <= sine_lookup(phase[PHASE_W-1 -: 6]);
  end

endmodule

// ==== pdm_modulator.sv ====
`timescale 1ns/100ps

module pdm_modulator import mic_audio_pkg::*; (
  input  logic                       audio_clk,
  input  logic                       reset,
  input  logic signed [SAMPLE_W-1:0] level,
  output logic                       pdm_out
);

  logic [SAMPLE_W-1:0] level_offset;
  logic [SAMPLE_W-1:0] acc;
  logic [SAMPLE_W:0]   acc_next;

  // level + 32768, flipping the sign bit is enough
  assign level_offset = {~level[SAMPLE_W-1], level[SAMPLE_W-2:0]};

  // residue from last cycle plus the new level
  assign acc_next = {1'b0, acc} + {1'b0, level_offset};

  // carry out is the one-bit output
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= acc_next[SAMPLE_W-1:0];
      pdm_out <= acc_next[SAMPLE_W];
    end
  end

endmodule

// ==== mic_audio_top.sv ====
`timescale 1ns/100ps

module mic_audio_top import mic_audio_pkg::*; #(
  parameter int unsigned        BCLK_HALF      = 16,
  parameter int unsigned        TRIGGER_PERIOD = 4096,
  parameter logic [PHASE_W-1:0] PHASE_INCR_A   = 32'h0100_0000,
  parameter logic [PHASE_W-1:0] PHASE_INCR_B   = 32'h0040_0000
) (
  input  logic                     audio_clk,
  input  logic                     reset,
  input  logic                     mic_data,
  input  logic                     tone_select,
  input  logic                     source_select,
  input  logic [1:0]               spk_enable,
  output logic                     i2s_clk,
  output logic                     lrcl_clk,
  output logic                     spkl,
  output logic                     spkr,
  output audio_sample_t            mic_sample,
  output audio_sample_t            decimated_sample,
  output logic signed [TONE_W-1:0] tone
);

  localparam int TRIG_W = (TRIGGER_PERIOD > 1) ? $clog2(TRIGGER_PERIOD) : 1;

  logic [TRIG_W-1:0]          trig_cnt;
  logic                       audio_trigger;
  logic signed [SAMPLE_W-1:0] held_audio;
  logic signed [SAMPLE_W-1:0] tone_level;
  logic signed [SAMPLE_W-1:0] pdm_level;
  logic                       pdm_out;

  i2s_receiver #(
    .BCLK_HALF(BCLK_HALF)
  ) u_i2s_receiver (
    .audio_clk (audio_clk),
    .reset     (reset),
    .mic_data  (mic_data),
    .i2s_clk   (i2s_clk),
    .lrcl_clk  (lrcl_clk),
    .mic_sample(mic_sample)
  );

  fir_decimator u_fir_decimator (
    .audio_clk (audio_clk),
    .reset     (reset),
    .sample_in (mic_sample),
    .sample_out(decimated_sample)
  );

  // periodic audio trigger for the tone
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      trig_cnt <= '0;
    end else if (trig_cnt == TRIG_W'(TRIGGER_PERIOD - 1)) begin
      trig_cnt <= '0;
    end else begin
      trig_cnt <= trig_cnt + 1'b1;
    end
  end

  assign audio_trigger = (trig_cnt == '0);

  sine_generator #(
    .PHASE_INCR_A(PHASE_INCR_A),
    .PHASE_INCR_B(PHASE_INCR_B)
  ) u_sine_generator (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .step       (audio_trigger),
    .tone_select(tone_select),
    .amplitude  (tone)
  );

  // hold decimated audio between strobes, silence after reset
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      held_audio <= '0;
    end else if (decimated_sample.valid) begin
      held_audio <= decimated_sample.data;
    end
  end

  // tone into the upper byte, same as sign extend and shift by 8
  assign tone_level = {tone, {(SAMPLE_W - TONE_W){1'b0}}};
  assign pdm_level  = source_select ? tone_level : held_audio;

  pdm_modulator u_pdm_modulator (
    .audio_clk(audio_clk),
    .reset    (reset),
    .level    (pdm_level),
    .pdm_out  (pdm_out)
  );

  // speaker gating
  assign spkl = pdm_out & spk_enable[0];
  assign spkr = pdm_out & spk_enable[1];

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic audio_clk,
  output logic reset
);

  initial begin
    audio_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) audio_clk = ~audio_clk;
    end
  end

  // release on a falling edge so the first active edge sees a clean level
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge audio_clk);
    @(negedge audio_clk);
    reset = 1'b0;
  end

endmodule

// ==== mic_audio_tb.sv ====
`timescale 1ns/100ps

module mic_audio_tb import mic_audio_pkg::*; ();

  localparam int unsigned BCLK_HALF      = 2;
  localparam int unsigned TRIGGER_PERIOD = 64;
  localparam logic [31:0] INCR_A         = 32'h0100_0000;
  localparam logic [31:0] INCR_B         = 32'h0040_0000;
  localparam real         CLK_PERIOD     = 8.0;
  localparam int          RESET_CYCLES   = 5;
  localparam int          FIR_TAPS [8]   = '{4, 16, 36, 72, 72, 36, 16, 4};
  localparam int          FIR_LATENCY    = 10;
  localparam int          FRAME_CYCLES   = 64 * 2 * BCLK_HALF;
  localparam int          GATE_CYCLES    = 1024;
  localparam int          DENSITY_CYCLES = 65536;
  localparam int          TONE_B_CYCLES  = 4096;
  localparam int          RUN_CYCLES     = RESET_CYCLES + 1 + 3 * GATE_CYCLES + DENSITY_CYCLES
                                           + TONE_B_CYCLES + 2 * FRAME_CYCLES;
  localparam int          RUN_FRAMES     = RUN_CYCLES / FRAME_CYCLES + 1;
  localparam real         TIMEOUT_NS     = (RUN_FRAMES + 8) * FRAME_CYCLES * CLK_PERIOD;

  logic              audio_clk;
  logic              reset;
  logic              mic_data;
  logic              tone_select;
  logic              source_select;
  logic [1:0]        spk_enable;
  logic              i2s_clk;
  logic              lrcl_clk;
  logic              spkl;
  logic              spkr;
  audio_sample_t     mic_sample;
  audio_sample_t     decimated_sample;
  logic signed [7:0] tone;

  logic [15:0]       sent_words [$];
  logic [15:0]       lfsr_state = 16'd17;
  int                bit_period = 0;
  int                captured_count = 0;
  int                dec_count = 0;
  longint            cyc = 0;
  longint            last_capture_cyc = 0;
  logic [31:0]       model_phase = '0;
  logic signed [7:0] exp_tone = '0;
  logic              active = 1'b0;

  tb_clock_gen #(
    .PERIOD_NS   (CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) u_clock_gen (
    .audio_clk(audio_clk),
    .reset    (reset)
  );

  mic_audio_top #(
    .BCLK_HALF     (BCLK_HALF),
    .TRIGGER_PERIOD(TRIGGER_PERIOD),
    .PHASE_INCR_A  (INCR_A),
    .PHASE_INCR_B  (INCR_B)
  ) DUT (
    .audio_clk       (audio_clk),
    .reset           (reset),
    .mic_data        (mic_data),
    .tone_select     (tone_select),
    .source_select   (source_select),
    .spk_enable      (spk_enable),
    .i2s_clk         (i2s_clk),
    .lrcl_clk        (lrcl_clk),
    .spkl            (spkl),
    .spkr            (spkr),
    .mic_sample      (mic_sample),
    .decimated_sample(decimated_sample),
    .tone            (tone)
  );

  task automatic check_value(input string name, input logic signed [63:0] got,
                             input logic signed [63:0] expected);
    if (got !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, expected);
      $display("Finished with errors");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  function automatic logic [15:0] next_word();
    logic [15:0] word;
    word = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      word = {word[14:0], lfsr_state[0]};
    end
    return word;
  endfunction

  // filter output over the first count captured words, newest last
  function automatic longint fir_ref(input int count);
    longint acc;
    longint y;
    acc = 0;
    for (int k = 0; k < 8; k++) begin
      if (count - 1 - k >= 0) begin
        acc += FIR_TAPS[k] * longint'($signed(sent_words[count - 1 - k]));
      end
    end
    y = acc >>> 8;
    if (y > 32767) begin
      y = 32767;
    end else if (y < -32768) begin
      y = -32768;
    end
    return y;
  endfunction

  // modulator input with the tone in the upper byte, offset to unsigned
  function automatic longint level_offset(input logic signed [7:0] amp);
    return longint'(amp) * 256 + 32768;
  endfunction

  task automatic run_cycles(input int cycles);
    repeat (cycles) @(negedge audio_clk);
  endtask

  task automatic check_reset_state();
    check_value("i2s_clk", i2s_clk, 0);
    check_value("lrcl_clk", lrcl_clk, 0);
    check_value("mic_sample.valid", mic_sample.valid, 0);
    check_value("decimated_sample.valid", decimated_sample.valid, 0);
    check_value("spkl", spkl, 0);
    check_value("spkr", spkr, 0);
  endtask

  // ones in the window must be the floor or ceiling of the summed levels
  task automatic measure_density(input int cycles);
    longint            ones;
    longint            level_sum;
    longint            floor_ones;
    longint            expected;
    logic signed [7:0] prev_tone;
    ones = 0;
    level_sum = 0;
    prev_tone = exp_tone;
    repeat (cycles) begin
      @(negedge audio_clk);
      ones += spkl;
      level_sum += level_offset(prev_tone);
      prev_tone = exp_tone;
    end
    floor_ones = level_sum / 65536;
    if (ones > floor_ones && (level_sum % 65536) != 0) begin
      expected = floor_ones + 1;
    end else begin
      expected = floor_ones;
    end
    check_value("spkl ones in window", ones, expected);
  endtask

  // mic model, one left word per frame, MSB first after the delay bit
  initial begin
    logic [15:0] word;
    logic        next_bit;
    mic_data = 1'b0;
    word = '0;
    @(negedge reset);
    forever begin
      @(negedge i2s_clk);
      bit_period = (bit_period + 1) % 64;
      if (bit_period == 1) begin
        word = next_word();
        sent_words.push_back(word);
      end
      if (bit_period >= 1 && bit_period <= 16) begin
        next_bit = word[16 - bit_period];
      end else begin
        next_bit = 1'b0;
      end
      @(negedge audio_clk);
      mic_data = next_bit;
    end
  end

  // compare just before each rising edge, then advance the tone model
  always @(posedge audio_clk) begin
    if (reset) begin
      cyc = 0;
      model_phase = '0;
      active = 1'b0;
    end else begin
      if (active) begin
        // bit clock toggles every BCLK_HALF cycles from reset
        check_value("i2s_clk", i2s_clk, (cyc / BCLK_HALF) % 2);
        check_value("lrcl_clk", lrcl_clk, bit_period >= 32);
        check_value("tone", tone, exp_tone);
        if (!spk_enable[0]) begin
          check_value("spkl", spkl, 0);
        end
        if (!spk_enable[1]) begin
          check_value("spkr", spkr, 0);
        end
        if (spk_enable == 2'b11) begin
          check_value("spkr", spkr, spkl);
        end
        if (mic_sample.valid) begin
          check_value("bit period at mic_sample.valid", bit_period, 16);
          check_value("words sent before capture", sent_words.size() > captured_count, 1);
          check_value("mic_sample.data", mic_sample.data, $signed(sent_words[captured_count]));
          captured_count++;
          last_capture_cyc = cyc;
        end
        if (decimated_sample.valid) begin
          dec_count++;
          check_value("captures per decimated_sample", captured_count, 2 * dec_count);
          check_value("decimated_sample latency", cyc - last_capture_cyc, FIR_LATENCY);
          check_value("decimated_sample.data", decimated_sample.data, fir_ref(2 * dec_count));
        end
      end
      exp_tone = sine_lookup(model_phase[31:26]);
      if (cyc % TRIGGER_PERIOD == 0) begin
        model_phase = model_phase + (tone_select ? INCR_B : INCR_A);
      end
      cyc++;
      active = 1'b1;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the test sequence completed");
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

  initial begin
    tone_select = 1'b0;
    source_select = 1'b1;
    // speakers open through reset, so their low level comes from the modulator
    spk_enable = 2'b11;
    repeat (RESET_CYCLES - 1) begin
      @(negedge audio_clk);
      check_reset_state();
    end
    wait (!reset);
    @(negedge audio_clk);
    check_reset_state();
    spk_enable = 2'b01;
    run_cycles(GATE_CYCLES);
    spk_enable = 2'b10;
    run_cycles(GATE_CYCLES);
    spk_enable = 2'b00;
    run_cycles(GATE_CYCLES);
    spk_enable = 2'b11;
    measure_density(DENSITY_CYCLES);
    tone_select = 1'b1;
    run_cycles(TONE_B_CYCLES);
    // right half of the frame, capture and filter are idle here
    wait (bit_period == 40);
    @(negedge audio_clk);
    check_value("mic_sample strobes", captured_count, sent_words.size());
    check_value("decimated_sample strobes", dec_count, captured_count / 2);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== files.f ====
mic_audio_pkg.sv
i2s_receiver.sv
fir_decimator.sv
sine_generator.sv
pdm_modulator.sv
mic_audio_top.sv
tb_clock_gen.sv
mic_audio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module mic_audio_tb -f files.f
./obj_dir/Vmic_audio_tb | tee sim.log
if grep -q "Finished with no errors" sim.log; then
  exit 0
else
  exit 1
fi
